//--- common/ttc_pkg.sv
// TTC lite shared definitions for register map, widths and bit positions
package ttc_pkg;

  // ------------------------------------------------
  // Bus and field widths
  // ------------------------------------------------
  localparam int data_w = 16;  // Data bus and all counter registers
  localparam int addr_w = 8;   // Byte address
  localparam int ck_w   = 5;   // Clock control field
  localparam int cc_w   = 7;   // Counter control field
  localparam int is_w   = 6;   // Interrupt status and enable

  // ------------------------------------------------
  // Register offsets, one word each
  // ------------------------------------------------
  localparam logic [addr_w-1:0] addr_clk_ctrl    = 8'h00;
  localparam logic [addr_w-1:0] addr_cntr_ctrl   = 8'h04;
  localparam logic [addr_w-1:0] addr_count_val   = 8'h08;  // Read only
  localparam logic [addr_w-1:0] addr_interval    = 8'h0C;
  localparam logic [addr_w-1:0] addr_match_1     = 8'h10;
  localparam logic [addr_w-1:0] addr_match_2     = 8'h14;
  localparam logic [addr_w-1:0] addr_match_3     = 8'h18;
  localparam logic [addr_w-1:0] addr_intr_status = 8'h1C;  // Read only, clear on read
  localparam logic [addr_w-1:0] addr_intr_en     = 8'h20;

  // Counter control bits
  localparam int cc_disable   = 0;  // Active low enable
  localparam int cc_interval  = 1;  // Interval mode, else overflow
  localparam int cc_decrement = 2;
  localparam int cc_match     = 3;
  localparam int cc_restart   = 4;
  localparam int cc_wave_dis  = 5;
  localparam int cc_wave_pol  = 6;
  localparam logic [cc_w-1:0] cc_reset_val = 7'b0000001;  // Counter disabled

  // Clock control fields
  localparam int ck_pre_en     = 0;
  localparam int ck_pre_val_lo = 1;  // Prescale value at bits 4 to 1
  localparam int ck_pre_val_w  = 4;

  // Interrupt status bits
  localparam int is_interval = 0;
  localparam int is_match_1  = 1;
  localparam int is_match_2  = 2;
  localparam int is_match_3  = 3;
  localparam int is_overflow = 4;
  localparam int is_event    = 5;  // Reserved, reads 0

endpackage

//--- src/ttc_reg_ctrl.sv
// TTC register control, turns bus accesses into write strobes and read data
`timescale 1ns/10ps

module ttc_reg_ctrl
  import ttc_pkg::*;
(
  input  logic              pclk8,
  input  logic              n_p_reset8,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [addr_w-1:0] paddr,
  output logic [data_w-1:0] prdata,
  output logic              clk_ctrl_sel,
  output logic              cntr_ctrl_reg_sel,
  output logic              interval_reg_sel,
  output logic              match_1_reg_sel,
  output logic              match_2_reg_sel,
  output logic              match_3_reg_sel,
  output logic              intr_en_sel,
  output logic              status_rd,
  input  logic [ck_w-1:0]   clk_ctrl_reg_out,
  input  logic [cc_w-1:0]   cntr_ctrl_reg_out,
  input  logic [data_w-1:0] count_val_out,
  input  logic [data_w-1:0] interval_reg_out,
  input  logic [data_w-1:0] match_1_reg_out,
  input  logic [data_w-1:0] match_2_reg_out,
  input  logic [data_w-1:0] match_3_reg_out,
  input  logic [is_w-1:0]   intr_status,
  input  logic [is_w-1:0]   intr_en_reg_out
);

  logic              wr_acc;   // Write access phase
  logic              rd_acc;   // Read access phase
  logic [addr_w-1:0] rd_addr;  // Address latched in read setup

  assign wr_acc = psel & penable & pwrite;
  assign rd_acc = psel & penable & ~pwrite;

  // ------------------------------------------------
  // Write strobes, exclusive by address
  // ------------------------------------------------
  assign clk_ctrl_sel      = wr_acc & (paddr == addr_clk_ctrl);
  assign cntr_ctrl_reg_sel = wr_acc & (paddr == addr_cntr_ctrl);
  assign interval_reg_sel  = wr_acc & (paddr == addr_interval);
  assign match_1_reg_sel   = wr_acc & (paddr == addr_match_1);
  assign match_2_reg_sel   = wr_acc & (paddr == addr_match_2);
  assign match_3_reg_sel   = wr_acc & (paddr == addr_match_3);
  assign intr_en_sel       = wr_acc & (paddr == addr_intr_en);

  // Status clear strobe
  assign status_rd = rd_acc & (rd_addr == addr_intr_status);

  // Capture read address at setup phase
  always_ff @(posedge pclk8 or negedge n_p_reset8)
  begin
    if (!n_p_reset8)
      rd_addr <= '0;
    else if (psel & ~penable & ~pwrite)
      rd_addr <= paddr;
  end

  // ------------------------------------------------
  // Read mux, zero outside read access
  // ------------------------------------------------
  always_comb
  begin
    prdata = '0;
    if (rd_acc)
    begin
      case (rd_addr)
        addr_clk_ctrl:    prdata = {{(data_w-ck_w){1'b0}}, clk_ctrl_reg_out};
        addr_cntr_ctrl:   prdata = {{(data_w-cc_w){1'b0}}, cntr_ctrl_reg_out};
        addr_count_val:   prdata = count_val_out;
        addr_interval:    prdata = interval_reg_out;
        addr_match_1:     prdata = match_1_reg_out;
        addr_match_2:     prdata = match_2_reg_out;
        addr_match_3:     prdata = match_3_reg_out;
        addr_intr_status: prdata = {{(data_w-is_w){1'b0}}, intr_status};
        addr_intr_en:     prdata = {{(data_w-is_w){1'b0}}, intr_en_reg_out};
        default:          prdata = '0;  // Unmapped
      endcase
    end
  end

endmodule

//--- ttc/ttc_prescaler.sv
// TTC prescaler, clock control register and divider giving the count enable
`timescale 1ns/10ps

module ttc_prescaler
  import ttc_pkg::*;
(
  input  logic              pclk8,
  input  logic              n_p_reset8,
  input  logic [data_w-1:0] pwdata,
  input  logic              clk_ctrl_sel,
  output logic [ck_w-1:0]   clk_ctrl_reg_out,
  output logic              count_en
);

  logic [ck_w-1:0]         clk_ctrl_reg;
  logic [data_w-1:0]       div_cnt;    // Divide counter
  logic [data_w-1:0]       div_term;   // Terminal count
  logic [ck_w-1:0]         pre_shift;  // Prescale value plus one
  logic [ck_pre_val_w-1:0] pre_val;
  logic                    pre_en;

  assign clk_ctrl_reg_out = clk_ctrl_reg;
  assign pre_en  = clk_ctrl_reg[ck_pre_en];
  assign pre_val = clk_ctrl_reg[ck_pre_val_lo +: ck_pre_val_w];

  // 2^(pre_val+1) - 1, wraps to all ones for the top value
  assign pre_shift = {1'b0, pre_val} + 5'd1;
  assign div_term  = ({{(data_w-1){1'b0}}, 1'b1} << pre_shift) - 1'b1;

  // Every cycle when prescaling is off
  assign count_en = ~pre_en | (div_cnt == div_term);

  always_ff @(posedge pclk8 or negedge n_p_reset8)
  begin
    if (!n_p_reset8)
      clk_ctrl_reg <= '0;
    else if (clk_ctrl_sel)
      clk_ctrl_reg <= pwdata[ck_w-1:0];
  end

  // ------------------------------------------------
  // Divider, restarts on any clock control write
  // ------------------------------------------------
  always_ff @(posedge pclk8 or negedge n_p_reset8)
  begin
    if (!n_p_reset8)
      div_cnt <= '0;
    else if (clk_ctrl_sel | ~pre_en)
      div_cnt <= '0;
    else if (div_cnt == div_term)
      div_cnt <= '0;                    // Wrap after pulse
    else
      div_cnt <= div_cnt + 1'b1;
  end

endmodule

//--- ttc/ttc_counter.sv
// TTC counter, up/down count in overflow or interval mode with match and wave
`timescale 1ns/10ps

module ttc_counter
  import ttc_pkg::*;
(
  input  logic              pclk8,
  input  logic              n_p_reset8,
  input  logic [data_w-1:0] pwdata,
  input  logic              count_en,
  input  logic              cntr_ctrl_reg_sel,
  input  logic              interval_reg_sel,
  input  logic              match_1_reg_sel,
  input  logic              match_2_reg_sel,
  input  logic              match_3_reg_sel,
  output logic [data_w-1:0] count_val_out,
  output logic [cc_w-1:0]   cntr_ctrl_reg_out,
  output logic [data_w-1:0] interval_reg_out,
  output logic [data_w-1:0] match_1_reg_out,
  output logic [data_w-1:0] match_2_reg_out,
  output logic [data_w-1:0] match_3_reg_out,
  output logic              interval_intr,
  output logic              overflow_intr,
  output logic [3:1]        match_intr,
  output logic              wave_out
);

  logic [cc_w-1:0]   cntr_ctrl_reg;
  logic [data_w-1:0] interval_reg;
  logic [data_w-1:0] match_1_reg;
  logic [data_w-1:0] match_2_reg;
  logic [data_w-1:0] match_3_reg;
  logic [data_w-1:0] count_val;
  logic              counting;      // Set once counting has begun
  logic              restart_temp;  // Restart was taken, clear the bit
  logic              intr_active;   // Counting, enabled, no restart
  logic              at_zero;
  logic              wave_q;

  assign cntr_ctrl_reg_out = cntr_ctrl_reg;
  assign interval_reg_out  = interval_reg;
  assign match_1_reg_out   = match_1_reg;
  assign match_2_reg_out   = match_2_reg;
  assign match_3_reg_out   = match_3_reg;
  assign count_val_out     = count_val;
  assign wave_out          = wave_q;

  // ------------------------------------------------
  // Interrupt levels from registered count
  // ------------------------------------------------
  assign at_zero     = (count_val == '0);
  assign intr_active = counting & ~cntr_ctrl_reg[cc_restart] & ~cntr_ctrl_reg[cc_disable];

  assign interval_intr = cntr_ctrl_reg[cc_interval] & at_zero & intr_active;
  assign overflow_intr = ~cntr_ctrl_reg[cc_interval] & at_zero & intr_active;
  assign match_intr[1] = cntr_ctrl_reg[cc_match] & (count_val == match_1_reg) & intr_active;
  assign match_intr[2] = cntr_ctrl_reg[cc_match] & (count_val == match_2_reg) & intr_active;
  assign match_intr[3] = cntr_ctrl_reg[cc_match] & (count_val == match_3_reg) & intr_active;

  // Register writes, restart bit self clears
  always_ff @(posedge pclk8 or negedge n_p_reset8)
  begin
    if (!n_p_reset8)
    begin
      cntr_ctrl_reg <= cc_reset_val;
      interval_reg  <= '0;
      match_1_reg   <= '0;
      match_2_reg   <= '0;
      match_3_reg   <= '0;
    end
    else
    begin
      if (cntr_ctrl_reg_sel)
        cntr_ctrl_reg <= pwdata[cc_w-1:0];
      else if (restart_temp)
        cntr_ctrl_reg[cc_restart] <= 1'b0;
      if (interval_reg_sel)
        interval_reg <= pwdata;
      if (match_1_reg_sel)
        match_1_reg <= pwdata;
      if (match_2_reg_sel)
        match_2_reg <= pwdata;
      if (match_3_reg_sel)
        match_3_reg <= pwdata;
    end
  end

  // ------------------------------------------------
  // Count, only on count_en
  // ------------------------------------------------
  always_ff @(posedge pclk8 or negedge n_p_reset8)
  begin
    if (!n_p_reset8)
    begin
      count_val    <= '0;
      counting     <= 1'b0;
      restart_temp <= 1'b0;
    end
    else if (count_en)
    begin
      if (cntr_ctrl_reg[cc_restart])
      begin
        // Start value depends on direction and mode
        if (!cntr_ctrl_reg[cc_decrement])
          count_val <= '0;
        else if (cntr_ctrl_reg[cc_interval])
          count_val <= interval_reg;
        else
          count_val <= '1;
        counting     <= 1'b0;
        restart_temp <= 1'b1;
      end
      else
      begin
        if (!cntr_ctrl_reg[cc_disable])
        begin
          if (cntr_ctrl_reg[cc_decrement])
            count_val <= at_zero ? (cntr_ctrl_reg[cc_interval] ? interval_reg : '1)
                                 : count_val - 1'b1;
          else if (cntr_ctrl_reg[cc_interval])
            count_val <= (count_val == interval_reg) ? '0 : count_val + 1'b1;
          else
            count_val <= count_val + 1'b1;  // Wraps FFFF to 0
          counting <= 1'b1;
        end
        restart_temp <= 1'b0;
      end
    end
  end

  // Waveform, toggles on match 1
  always_ff @(posedge pclk8 or negedge n_p_reset8)
  begin
    if (!n_p_reset8)
      wave_q <= cc_reset_val[cc_wave_pol];
    else if (cntr_ctrl_reg_sel)
      wave_q <= pwdata[cc_wave_pol];          // Back to new polarity
    else if (count_en)
    begin
      if (cntr_ctrl_reg[cc_restart])
        wave_q <= cntr_ctrl_reg[cc_wave_pol];
      else if (match_intr[1] & ~cntr_ctrl_reg[cc_wave_dis])
        wave_q <= ~wave_q;
    end
  end

endmodule

//--- ttc/ttc_intr_status.sv
// TTC interrupt status, sticky clear-on-read bits with enable mask and irq
`timescale 1ns/10ps

module ttc_intr_status
  import ttc_pkg::*;
(
  input  logic              pclk8,
  input  logic              n_p_reset8,
  input  logic [data_w-1:0] pwdata,
  input  logic              intr_en_sel,
  input  logic              status_rd,
  input  logic              interval_intr,
  input  logic              overflow_intr,
  input  logic [3:1]        match_intr,
  output logic [is_w-1:0]   intr_status,
  output logic [is_w-1:0]   intr_en_reg_out,
  output logic              irq
);

  logic [is_w-1:0] status_q;
  logic [is_w-1:0] intr_en_q;
  logic [is_w-1:0] intr_set;  // Levels mapped to status bits
  logic            irq_q;

  assign intr_status     = status_q;
  assign intr_en_reg_out = intr_en_q;
  assign irq             = irq_q;

  always_comb
  begin
    intr_set              = '0;
    intr_set[is_interval] = interval_intr;
    intr_set[is_match_1]  = match_intr[1];
    intr_set[is_match_2]  = match_intr[2];
    intr_set[is_match_3]  = match_intr[3];
    intr_set[is_overflow] = overflow_intr;
    intr_set[is_event]    = 1'b0;  // Reserved
  end

  // ------------------------------------------------
  // Sticky status, set wins over read clear
  // ------------------------------------------------
  always_ff @(posedge pclk8 or negedge n_p_reset8)
  begin
    if (!n_p_reset8)
      status_q <= '0;
    else if (status_rd)
      status_q <= intr_set;
    else
      status_q <= status_q | intr_set;
  end

  // Enable mask and registered irq
  always_ff @(posedge pclk8 or negedge n_p_reset8)
  begin
    if (!n_p_reset8)
    begin
      intr_en_q <= '0;
      irq_q     <= 1'b0;
    end
    else
    begin
      if (intr_en_sel)
        intr_en_q <= pwdata[is_w-1:0];
      irq_q <= |(status_q & intr_en_q);  // One cycle behind status
    end
  end

endmodule

//--- ttc/ttc_top.sv
// TTC lite top, bus decode, prescaler, counter and interrupt status
`timescale 1ns/10ps

module ttc_top
  import ttc_pkg::*;
(
  input  logic              pclk8,
  input  logic              n_p_reset8,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [addr_w-1:0] paddr,
  input  logic [data_w-1:0] pwdata,
  output logic [data_w-1:0] prdata,
  output logic              irq,
  output logic              wave_out
);

  // ------------------------------------------------
  // Strobes and register values
  // ------------------------------------------------
  logic              clk_ctrl_sel, cntr_ctrl_reg_sel, interval_reg_sel;
  logic              match_1_reg_sel, match_2_reg_sel, match_3_reg_sel;
  logic              intr_en_sel, status_rd, count_en;
  logic              interval_intr, overflow_intr;
  logic [3:1]        match_intr;
  logic [ck_w-1:0]   clk_ctrl_reg_out;
  logic [cc_w-1:0]   cntr_ctrl_reg_out;
  logic [data_w-1:0] count_val_out, interval_reg_out;
  logic [data_w-1:0] match_1_reg_out, match_2_reg_out, match_3_reg_out;
  logic [is_w-1:0]   intr_status, intr_en_reg_out;

  ttc_reg_ctrl u_reg_ctrl (
    .pclk8, .n_p_reset8, .psel, .penable, .pwrite, .paddr, .prdata,
    .clk_ctrl_sel, .cntr_ctrl_reg_sel, .interval_reg_sel,
    .match_1_reg_sel, .match_2_reg_sel, .match_3_reg_sel,
    .intr_en_sel, .status_rd,
    .clk_ctrl_reg_out, .cntr_ctrl_reg_out, .count_val_out, .interval_reg_out,
    .match_1_reg_out, .match_2_reg_out, .match_3_reg_out,
    .intr_status, .intr_en_reg_out
  );

  ttc_prescaler u_prescaler (
    .pclk8, .n_p_reset8, .pwdata, .clk_ctrl_sel, .clk_ctrl_reg_out, .count_en
  );

  ttc_counter u_counter (
    .pclk8, .n_p_reset8, .pwdata, .count_en,
    .cntr_ctrl_reg_sel, .interval_reg_sel,
    .match_1_reg_sel, .match_2_reg_sel, .match_3_reg_sel,
    .count_val_out, .cntr_ctrl_reg_out, .interval_reg_out,
    .match_1_reg_out, .match_2_reg_out, .match_3_reg_out,
    .interval_intr, .overflow_intr, .match_intr, .wave_out
  );

  // Levels in, irq out
  ttc_intr_status u_intr_status (
    .pclk8, .n_p_reset8, .pwdata, .intr_en_sel, .status_rd,
    .interval_intr, .overflow_intr, .match_intr,
    .intr_status, .intr_en_reg_out, .irq
  );

endmodule

//--- testbench/ttc_props.sv
// TTC lite properties, bound checks for counting, prescaling, interrupts and waveform
`timescale 1ns/10ps

module ttc_props
  import ttc_pkg::*;
(
  input logic              pclk8,
  input logic              n_p_reset8,
  input logic [data_w-1:0] pwdata,
  input logic              count_en,
  input logic              clk_ctrl_sel,
  input logic              cntr_ctrl_reg_sel,
  input logic              status_rd,
  input logic [ck_w-1:0]   clk_ctrl_reg_out,
  input logic [cc_w-1:0]   cntr_ctrl_reg_out,
  input logic [data_w-1:0] count_val_out,
  input logic [data_w-1:0] interval_reg_out,
  input logic [data_w-1:0] match_1_reg_out,
  input logic              interval_intr,
  input logic              overflow_intr,
  input logic [3:1]        match_intr,
  input logic [is_w-1:0]   intr_status,
  input logic [is_w-1:0]   intr_en_reg_out,
  input logic              irq,
  input logic              wave_out,
  input logic              counting
);

  int unsigned       fail_cnt = 0;  // Read by the testbench
  logic [16:0]       gap;           // Cycles since last count_en
  logic [cc_w-1:0]   cc;
  logic              run;           // Enabled and not restarting
  logic [16:0]       pre_term;

  assign cc  = cntr_ctrl_reg_out;
  assign run = ~cc[cc_restart] & ~cc[cc_disable];
  assign pre_term = (17'd1 << (clk_ctrl_reg_out[ck_pre_val_lo +: ck_pre_val_w] + 1)) - 17'd1;

  always_ff @(posedge pclk8 or negedge n_p_reset8)
  begin
    if (!n_p_reset8)
      gap <= '0;
    else if (clk_ctrl_sel | count_en)
      gap <= '0;
    else
      gap <= gap + 1'b1;
  end

  default disable iff (!n_p_reset8);

  // --------------------------------------------------
  // Counting in overflow mode
  // --------------------------------------------------
  a_inc: assert property (@(posedge pclk8)
    count_en && run && !cc[cc_decrement] && !cc[cc_interval]
    |=> count_val_out == 16'($past(count_val_out) + 16'd1))
    else
    begin
      $error("increment step wrong");
      fail_cnt++;
    end
  a_dec: assert property (@(posedge pclk8)
    count_en && run && cc[cc_decrement] && !cc[cc_interval]
    |=> count_val_out == 16'($past(count_val_out) - 16'd1))  // 0 wraps to FFFF
    else
    begin
      $error("decrement step wrong");
      fail_cnt++;
    end
  a_ovf: assert property (@(posedge pclk8)
    overflow_intr |-> count_val_out == 0 && run && !cc[cc_interval])
    else
    begin
      $error("overflow level away from zero");
      fail_cnt++;
    end
  // Wrap to zero in either direction
  a_ovf_hit: assert property (@(posedge pclk8)
    count_en && run && !cc[cc_interval] && !cntr_ctrl_reg_sel
    && count_val_out == (cc[cc_decrement] ? 16'h0001 : 16'hFFFF) |=> overflow_intr)
    else
    begin
      $error("overflow level missing at wrap");
      fail_cnt++;
    end
  a_hold: assert property (@(posedge pclk8)
    !count_en |=> count_val_out == $past(count_val_out))
    else
    begin
      $error("count moved without count_en");
      fail_cnt++;
    end

  // Interval mode bounds and wrap
  a_bound: assert property (@(posedge pclk8)
    cc[cc_interval] && run && counting |-> count_val_out <= interval_reg_out)
    else
    begin
      $error("count outside interval");
      fail_cnt++;
    end
  a_iwrap: assert property (@(posedge pclk8)
    count_en && run && cc[cc_interval] && !cc[cc_decrement]
    && count_val_out == interval_reg_out |=> count_val_out == 0)
    else
    begin
      $error("interval up wrap wrong");
      fail_cnt++;
    end
  a_dwrap: assert property (@(posedge pclk8)
    count_en && run && cc[cc_interval] && cc[cc_decrement]
    && count_val_out == 0 |=> count_val_out == $past(interval_reg_out))
    else
    begin
      $error("interval down wrap wrong");
      fail_cnt++;
    end

  // --------------------------------------------------
  // Status, irq and clear on read
  // --------------------------------------------------
  a_iset: assert property (@(posedge pclk8)
    interval_intr |=> intr_status[is_interval])
    else
    begin
      $error("interval status not set");
      fail_cnt++;
    end
  a_mset: assert property (@(posedge pclk8)
    cc[cc_match] && run && counting
    && count_val_out == match_1_reg_out |=> intr_status[is_match_1])
    else
    begin
      $error("match 1 status not set");
      fail_cnt++;
    end
  // Match bits rise only with cc_match set
  a_mdis: assert property (@(posedge pclk8)
    (|(intr_status[is_match_3:is_match_1] & ~$past(intr_status[is_match_3:is_match_1])))
    |-> $past(cc[cc_match]))
    else
    begin
      $error("match status set without cc_match");
      fail_cnt++;
    end
  a_clr: assert property (@(posedge pclk8)
    status_rd && !interval_intr |=> !intr_status[is_interval])
    else
    begin
      $error("status read did not clear");
      fail_cnt++;
    end
  a_irq: assert property (@(posedge pclk8)
    $rose(intr_status[is_interval]) && intr_en_reg_out[is_interval] |=> irq)
    else
    begin
      $error("irq not one cycle behind status");
      fail_cnt++;
    end

  // Prescaler pulse spacing
  a_pre: assert property (@(posedge pclk8)
    clk_ctrl_reg_out[ck_pre_en] && !$past(clk_ctrl_sel)
    |-> count_en == (gap == pre_term))
    else
    begin
      $error("prescaler spacing wrong");
      fail_cnt++;
    end

  // --------------------------------------------------
  // Restart and waveform
  // --------------------------------------------------
  a_rst_val: assert property (@(posedge pclk8)
    count_en && cc[cc_restart] |=> count_val_out ==
    ($past(cc[cc_decrement]) ? ($past(cc[cc_interval]) ? $past(interval_reg_out)
    : 16'hFFFF) : 16'h0000))
    else
    begin
      $error("restart start value wrong");
      fail_cnt++;
    end
  a_rst_clr: assert property (@(posedge pclk8)
    count_en && cc[cc_restart] && !cntr_ctrl_reg_sel
    ##1 !cntr_ctrl_reg_sel |=> !cc[cc_restart])
    else
    begin
      $error("restart bit did not clear");
      fail_cnt++;
    end
  a_wtog: assert property (@(posedge pclk8)
    count_en && match_intr[1] && !cc[cc_wave_dis] && !cntr_ctrl_reg_sel
    |=> wave_out != $past(wave_out))
    else
    begin
      $error("wave did not toggle");
      fail_cnt++;
    end
  a_wfix: assert property (@(posedge pclk8)
    cc[cc_wave_dis] && !cc[cc_restart] && !cntr_ctrl_reg_sel
    |=> wave_out == $past(wave_out))
    else
    begin
      $error("disabled wave moved");
      fail_cnt++;
    end
  a_wpol: assert property (@(posedge pclk8)
    cntr_ctrl_reg_sel |=> wave_out == $past(pwdata[cc_wave_pol]))
    else
    begin
      $error("wave not at polarity after control write");
      fail_cnt++;
    end

endmodule

bind ttc_top ttc_props u_props (.*, .counting(u_counter.counting));

//--- testbench/ttc_tb.sv
// TTC lite testbench, drives the register bus through each timer mode
`timescale 1ns/10ps

module ttc_tb;
  import ttc_pkg::*;

  localparam int timeout_cycles = 4000;  // Several times the length of all tests

  logic              pclk8;
  logic              n_p_reset8;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [addr_w-1:0] paddr;
  logic [data_w-1:0] pwdata;
  logic [data_w-1:0] prdata;
  logic              irq;
  logic              wave_out;

  logic [31:0] seed = 32'd55784;
  int          errs = 0;       // Readback mismatches
  int          cycles = 0;
  int          passed = 0;
  int          failed = 0;
  int          base;

  ttc_top uut (.*);

  initial
  begin
    pclk8 = 1'b0;
    forever #20 pclk8 = ~pclk8;
  end

  // Run limit
  always @(posedge pclk8)
  begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles)
    begin
      $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [15:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;  // LCG step
    return seed[30:15];
  endfunction

  function automatic int total_fails();
    return errs + uut.u_props.fail_cnt;
  endfunction

  // --------------------------------------------------
  // Bus tasks, inputs change 2 ns after the edge
  // --------------------------------------------------
  task automatic bus_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
    @(posedge pclk8);
    #2 psel = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge pclk8);
    #2 penable = 1'b1;
    @(posedge pclk8);  // Write lands here
    #2 psel = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic bus_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data);
    @(posedge pclk8);
    #2 psel = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge pclk8);
    #2 penable = 1'b1;
    #10 data = prdata;  // Stable mid access phase
    @(posedge pclk8);
    #2 psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check_read(input logic [addr_w-1:0] addr, input logic [data_w-1:0] exp);
    logic [data_w-1:0] got;
    bus_read(addr, got);
    if (got !== exp)
    begin
      $display("error at %0t: addr %h read %h, expected %h", $time, addr, got, exp);
      errs++;
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge pclk8);
  endtask

  task automatic report_test(input string name);
    if (total_fails() == base)
    begin
      passed++;
      $display("test %s: ok", name);
    end
    else
    begin
      failed++;
      $display("test %s: %0d failures", name, total_fails() - base);
    end
    base = total_fails();
  endtask

  initial
  begin
    logic [data_w-1:0] v;
    logic [data_w-1:0] st;
    n_p_reset8 = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    base = 0;
    repeat (16) @(posedge pclk8);
    #2 n_p_reset8 = 1'b1;

    // Readback of writable registers
    for (int i = 0; i < 4; i++)
    begin
      v = next_rand();
      bus_write(addr_interval, v);
      check_read(addr_interval, v);
      v = next_rand();
      bus_write(addr_match_1, v);
      check_read(addr_match_1, v);
      v = next_rand();
      bus_write(addr_match_2, v);
      check_read(addr_match_2, v);
      v = next_rand();
      bus_write(addr_match_3, v);
      check_read(addr_match_3, v);
      v = next_rand() & 16'h001F;
      bus_write(addr_clk_ctrl, v);
      check_read(addr_clk_ctrl, v);
      v = next_rand() & 16'h003F;
      bus_write(addr_intr_en, v);
      check_read(addr_intr_en, v);
    end
    bus_write(addr_count_val, 16'h1234);
    check_read(addr_count_val, 16'h0000);
    bus_write(addr_intr_status, 16'h003F);
    check_read(addr_intr_status, 16'h0000);
    bus_write(8'h24, 16'hBEEF);            // Unmapped
    check_read(8'h24, 16'h0000);
    bus_write(addr_clk_ctrl, 16'h0000);
    bus_write(addr_intr_en, 16'h003F);
    report_test("readback");

    // Overflow mode, both wraps reached from FFFF start
    bus_write(addr_cntr_ctrl, 16'h0014);   // Restart, decrement
    wait_cycles(4);
    bus_write(addr_cntr_ctrl, 16'h0000);   // Up through FFFF to 0
    wait_cycles(10);
    bus_write(addr_cntr_ctrl, 16'h0004);   // Down through 0 to FFFF
    wait_cycles(10);
    bus_read(addr_intr_status, st);
    report_test("overflow");

    // Interval mode, up then down
    bus_write(addr_interval, 16'd10);
    bus_write(addr_cntr_ctrl, 16'h0012);
    wait_cycles(30);
    check_read(addr_intr_status, 16'h0001);
    bus_write(addr_cntr_ctrl, 16'h0016);
    wait_cycles(30);
    bus_read(addr_intr_status, st);
    report_test("interval");

    // Match mode on and off
    bus_write(addr_match_1, 16'd3);
    bus_write(addr_match_2, 16'd5);
    bus_write(addr_match_3, 16'd7);
    bus_write(addr_cntr_ctrl, 16'h001A);
    wait_cycles(30);
    bus_write(addr_cntr_ctrl, 16'h0012);
    wait_cycles(4);
    check_read(addr_intr_status, 16'h000F);  // Interval and all three match bits
    wait_cycles(30);
    bus_read(addr_intr_status, st);
    if ((st & 16'h000E) != 0)
    begin
      $display("error at %0t: match status %h with cc_match clear", $time, st);
      errs++;
    end
    report_test("match");

    // Prescale by 8
    bus_write(addr_clk_ctrl, 16'h0005);
    bus_write(addr_cntr_ctrl, 16'h0010);
    wait_cycles(80);
    bus_write(addr_clk_ctrl, 16'h0000);
    report_test("prescaler");

    // Restart and waveform
    bus_write(addr_match_1, 16'd4);
    bus_write(addr_interval, 16'd8);
    bus_write(addr_cntr_ctrl, 16'h001A);
    wait_cycles(40);
    bus_write(addr_cntr_ctrl, 16'h003A);   // Wave disabled
    wait_cycles(20);
    bus_write(addr_cntr_ctrl, 16'h005A);   // Polarity high
    wait_cycles(20);
    check_read(addr_cntr_ctrl, 16'h004A);  // Restart bit gone
    report_test("restart_wave");

    $display("tests passed %0d, failed %0d, failures %0d", passed, failed, total_fails());
    if (total_fails() == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- compile.f
common/ttc_pkg.sv
src/ttc_reg_ctrl.sv
ttc/ttc_prescaler.sv
ttc/ttc_counter.sv
ttc/ttc_intr_status.sv
ttc/ttc_top.sv
testbench/ttc_props.sv
testbench/ttc_tb.sv

//--- Bender.yml
package:
  name: ttc_lite

sources:
  - common/ttc_pkg.sv
  - src/ttc_reg_ctrl.sv
  - ttc/ttc_prescaler.sv
  - ttc/ttc_counter.sv
  - ttc/ttc_intr_status.sv
  - ttc/ttc_top.sv
  - target: test
    files:
      - testbench/ttc_props.sv
      - testbench/ttc_tb.sv
